/* flist.f */
design/fxp_format_pkg.sv
design/div_ctrl_pkg.sv
design/div_operand_stage.sv
design/div_nonrestoring_core.sv
design/div_result_stage.sv
design/fxp_divide_top.sv
bench/fxp_divide_assertions.sv
bench/fxp_divide_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the fixed-point divide testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module fxp_divide_tb \
    -Mdir obj_dir \
    -f flist.f
if [ $? -ne 0 ]; then
    echo "run_sim: Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/Vfxp_divide_tb 2>&1)
sim_status=$?
printf '%s\n' "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "run_sim: simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_output" | grep -Fqx "ALL TESTS PASSED"; then
    echo "run_sim: simulation passed"
    exit 0
fi

echo "run_sim: simulation failed"
exit 1

/* bench/fxp_divide_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fxp_divide_tb;

    localparam int D_WIDTH  = fxp_format_pkg::DEFAULT_D_WIDTH;
    localparam int Q_BITS   = fxp_format_pkg::DEFAULT_Q_BITS;
    localparam int ED_WIDTH = D_WIDTH + Q_BITS + 1;
    localparam int LATENCY  = ED_WIDTH + 3; // capture edge to valid_out sample
    localparam int NUM_OPS  = 8 + 200 + 4 + 10 + 1 + 2;
    localparam int TIMEOUT_CYCLES = 10 + NUM_OPS * (ED_WIDTH + 6) + 100;
    localparam int unsigned SEED  = 32'hfe7a_0a13;

    localparam logic signed [D_WIDTH-1:0] MAX_VAL = {1'b0, {(D_WIDTH-1){1'b1}}};
    localparam logic signed [D_WIDTH-1:0] MIN_VAL = {1'b1, {(D_WIDTH-1){1'b0}}};
    localparam logic signed [D_WIDTH-1:0] ONE     = D_WIDTH'(1 << Q_BITS); // 1.0

    logic                      clock;
    logic                      reset;
    logic                      valid_in;
    logic signed [D_WIDTH-1:0] dividend;
    logic signed [D_WIDTH-1:0] divisor;
    logic signed [D_WIDTH-1:0] quotient;
    div_ctrl_pkg::div_status_t status;
    logic                      valid_out;
    logic                      busy;

    int cycle_count;
    int check_count;
    int error_count;
    int test_errors;
    int tests_run;
    int tests_failed;

    fxp_divide_top #(
        .D_WIDTH (D_WIDTH),
        .Q_BITS  (Q_BITS)
    ) DUT (
        .clock     (clock),
        .reset     (reset),
        .valid_in  (valid_in),
        .dividend  (dividend),
        .divisor   (divisor),
        .quotient  (quotient),
        .status    (status),
        .valid_out (valid_out),
        .busy      (busy)
    );

    always #50 clock = ~clock;

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // rounded magnitude quotient, sign restore and saturation
    function automatic void model_divide(
        input  logic signed [D_WIDTH-1:0] a,
        input  logic signed [D_WIDTH-1:0] b,
        output logic signed [D_WIDTH-1:0] exp_q,
        output div_ctrl_pkg::div_status_t exp_s
    );
        longint num_mag;
        longint den_mag;
        longint q_mag;
        longint limit;
        bit     neg;
        limit   = longint'(1) << (D_WIDTH - 1);
        num_mag = (a < 0) ? -longint'(a) : longint'(a);
        den_mag = (b < 0) ? -longint'(b) : longint'(b);
        neg     = (a < 0) != (b < 0);
        if (den_mag == 0) begin
            exp_q = (a < 0) ? MIN_VAL : MAX_VAL;
            exp_s = div_ctrl_pkg::STATUS_DIV_ZERO;
        end else begin
            q_mag = ((num_mag << Q_BITS) + den_mag / 2) / den_mag;
            if (!neg && q_mag >= limit) begin
                exp_q = MAX_VAL;
                exp_s = div_ctrl_pkg::STATUS_OVERFLOW;
            end else if (neg && q_mag > limit) begin
                exp_q = MIN_VAL;
                exp_s = div_ctrl_pkg::STATUS_OVERFLOW;
            end else begin
                exp_q = neg ? D_WIDTH'(-q_mag) : D_WIDTH'(q_mag);
                exp_s = div_ctrl_pkg::STATUS_OK;
            end
        end
    endfunction

    task automatic compare_result(
        input string                     test_name,
        input logic signed [D_WIDTH-1:0] exp_q,
        input div_ctrl_pkg::div_status_t exp_s
    );
        check_count += 2;
        assert (quotient === exp_q) else begin
            $display("FAILED %s: quotient expected %0d actual %0d", test_name, exp_q, quotient);
            test_errors++;
        end
        assert (status === exp_s) else begin
            $display("FAILED %s: status expected %s actual %s",
                     test_name, exp_s.name(), status.name());
            test_errors++;
        end
    endtask

    task automatic wait_until_idle();
        @(negedge clock);
        while (busy) begin
            @(negedge clock);
        end
    endtask

    // one division from strobe to result, latency checked too
    task automatic issue_and_wait(
        input string                     test_name,
        input logic signed [D_WIDTH-1:0] a,
        input logic signed [D_WIDTH-1:0] b
    );
        logic signed [D_WIDTH-1:0] exp_q;
        div_ctrl_pkg::div_status_t exp_s;
        int                        waited;
        model_divide(a, b, exp_q, exp_s);
        wait_until_idle();
        @(posedge clock);
        valid_in <= 1'b1;
        dividend <= a;
        divisor  <= b;
        @(posedge clock); // capture edge
        valid_in <= 1'b0;
        waited = 0;
        do begin
            @(negedge clock);
            waited++;
        end while (!valid_out && waited < LATENCY + 3);
        check_count++;
        assert (valid_out && waited == LATENCY) else begin
            if (!valid_out) begin
                $display("%s: no valid_out within %0d cycles of the capture", test_name, waited);
            end else begin
                $display("FAILED %s: latency expected %0d actual %0d", test_name, LATENCY, waited);
            end
            test_errors++;
        end
        if (valid_out) begin
            compare_result(test_name, exp_q, exp_s);
        end
    endtask

    task automatic report_test(input string test_name);
        tests_run++;
        error_count += test_errors;
        if (test_errors == 0) begin
            $display("test %s: passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, test_errors);
        end
    endtask

    task automatic directed_signs();
        logic signed [D_WIDTH-1:0] a;
        logic signed [D_WIDTH-1:0] b;
        int                        s;
        test_errors = 0;
        for (s = 0; s < 4; s++) begin
            a = D_WIDTH'(3 << Q_BITS); // 3.0 / 1.5
            b = D_WIDTH'(3 << (Q_BITS - 1));
            issue_and_wait("directed_signs", s[0] ? -a : a, s[1] ? -b : b);
            a = D_WIDTH'(1 << (Q_BITS - 2)); // 0.25 / 2.0
            b = D_WIDTH'(2 << Q_BITS);
            issue_and_wait("directed_signs", s[0] ? -a : a, s[1] ? -b : b);
        end
        report_test("directed_signs");
    endtask

    task automatic random_ops();
        logic signed [D_WIDTH-1:0] a;
        logic signed [D_WIDTH-1:0] b;
        int                        i;
        test_errors = 0;
        for (i = 0; i < 200; i++) begin
            a = D_WIDTH'($urandom);
            b = D_WIDTH'($urandom);
            if (i % 3 == 0) begin
                b = b >>> ($urandom % D_WIDTH); // small divisors reach overflow
            end
            issue_and_wait("random_ops", a, b);
        end
        report_test("random_ops");
    endtask

    task automatic divide_by_zero();
        test_errors = 0;
        issue_and_wait("divide_by_zero", D_WIDTH'(1000), '0);
        issue_and_wait("divide_by_zero", D_WIDTH'(-1000), '0);
        issue_and_wait("divide_by_zero", '0, '0);
        issue_and_wait("divide_by_zero", MIN_VAL, '0);
        report_test("divide_by_zero");
    endtask

    task automatic extremes();
        test_errors = 0;
        issue_and_wait("extremes", MIN_VAL, MIN_VAL);
        issue_and_wait("extremes", MIN_VAL, D_WIDTH'(1));
        issue_and_wait("extremes", MAX_VAL, D_WIDTH'(1));
        issue_and_wait("extremes", MIN_VAL, ONE); // exactly the most negative result
        issue_and_wait("extremes", MAX_VAL, ONE);
        issue_and_wait("extremes", MAX_VAL, -ONE);
        issue_and_wait("extremes", D_WIDTH'(1), MIN_VAL);
        issue_and_wait("extremes", MIN_VAL, D_WIDTH'(-1));
        issue_and_wait("extremes", D_WIDTH'(100), D_WIDTH'(-1));
        issue_and_wait("extremes", D_WIDTH'(200), D_WIDTH'(1));
        report_test("extremes");
    endtask

    task automatic ignore_while_busy();
        logic signed [D_WIDTH-1:0] a;
        logic signed [D_WIDTH-1:0] b;
        logic signed [D_WIDTH-1:0] exp_q;
        div_ctrl_pkg::div_status_t exp_s;
        int                        n;
        int                        pulses;
        int                        first_seen;
        test_errors = 0;
        pulses      = 0;
        first_seen  = 0;
        a = D_WIDTH'(5 << Q_BITS);
        b = D_WIDTH'(-(2 << Q_BITS));
        model_divide(a, b, exp_q, exp_s);
        wait_until_idle();
        @(posedge clock);
        valid_in <= 1'b1;
        dividend <= a;
        divisor  <= b;
        @(posedge clock);
        for (n = 1; n <= LATENCY + 3; n++) begin
            if (n <= LATENCY && n % 2 == 1) begin
                valid_in <= 1'b1; // other operands, must be dropped
                dividend <= D_WIDTH'($urandom);
                divisor  <= D_WIDTH'($urandom);
            end else begin
                valid_in <= 1'b0;
            end
            @(negedge clock);
            if (valid_out) begin
                pulses++;
                if (first_seen == 0) begin
                    first_seen = n;
                end
            end
            @(posedge clock);
        end
        check_count += 2;
        assert (pulses == 1) else begin
            $display("FAILED ignore_while_busy: valid_out pulses expected 1 actual %0d", pulses);
            test_errors++;
        end
        assert (first_seen == LATENCY) else begin
            $display("FAILED ignore_while_busy: latency expected %0d actual %0d",
                     LATENCY, first_seen);
            test_errors++;
        end
        compare_result("ignore_while_busy", exp_q, exp_s);
        report_test("ignore_while_busy");
    endtask

    task automatic reset_state();
        test_errors = 0;
        // leaves a saturated result and a non-default status behind
        issue_and_wait("reset_state", MAX_VAL, '0);
        wait_until_idle();
        @(posedge clock);
        valid_in <= 1'b1;
        dividend <= ONE;
        divisor  <= ONE;
        @(posedge clock);
        valid_in <= 1'b0;
        repeat (5) @(posedge clock); // reset lands mid-division, busy high
        reset <= 1'b1;
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_count++;
        assert (!valid_out && !busy) else begin
            $display("reset_state: valid_out or busy is high after reset");
            test_errors++;
        end
        compare_result("reset_state", '0, div_ctrl_pkg::STATUS_OK);
        report_test("reset_state");
    endtask

    initial begin
        clock        = 1'b0;
        reset        = 1'b1;
        valid_in     = 1'b0;
        dividend     = '0;
        divisor      = '0;
        cycle_count  = 0;
        check_count  = 0;
        error_count  = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(SEED));
        repeat (10) @(posedge clock);
        reset <= 1'b0;

        directed_signs();
        random_ops();
        divide_by_zero();
        extremes();
        ignore_while_busy();
        reset_state();

        $display("tests run %0d, tests failed %0d, checks %0d, check errors %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/fxp_divide_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module fxp_divide_assertions #(
    parameter int ED_WIDTH = 25
) (
    input logic clock,
    input logic reset,
    input logic valid_in,
    input logic valid_out,
    input logic busy
);

    a_single_pulse: assert property (@(posedge clock) disable iff (reset)
        valid_out |=> !valid_out)
        else $error("valid_out high on two consecutive cycles");

    a_valid_while_busy: assert property (@(posedge clock) disable iff (reset)
        valid_out |-> busy)
        else $error("valid_out high while busy is low");

    // unit frees itself right after delivering the result
    a_busy_release: assert property (@(posedge clock) disable iff (reset)
        valid_out |=> !busy)
        else $error("busy still high on the edge after valid_out");

    a_fixed_latency: assert property (@(posedge clock) disable iff (reset)
        (valid_in && !busy) |-> ##(ED_WIDTH + 3) valid_out)
        else $error("valid_out missing at the fixed latency after a capture");

endmodule

bind fxp_divide_top fxp_divide_assertions #(
    .ED_WIDTH (ED_WIDTH)
) u_assertions (
    .clock     (clock),
    .reset     (reset),
    .valid_in  (valid_in),
    .valid_out (valid_out),
    .busy      (busy)
);

`default_nettype wire

/* design/fxp_divide_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fxp_divide_top #(
    parameter int D_WIDTH = fxp_format_pkg::DEFAULT_D_WIDTH,
    parameter int Q_BITS  = fxp_format_pkg::DEFAULT_Q_BITS
) (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       valid_in,
    input  logic signed [D_WIDTH-1:0]  dividend,
    input  logic signed [D_WIDTH-1:0]  divisor,
    output logic signed [D_WIDTH-1:0]  quotient,
    output div_ctrl_pkg::div_status_t  status,
    output logic                       valid_out,
    output logic                       busy
);

    // widest core the format allows, one bit for the rounding carry
    localparam int ED_WIDTH = D_WIDTH + Q_BITS + 1;

    logic                op_valid;
    logic                negate;
    logic                divisor_zero;
    logic                dividend_neg;
    logic [D_WIDTH-1:0]  dividend_mag;
    logic [D_WIDTH-1:0]  divisor_mag;
    logic                core_done;
    logic [ED_WIDTH-1:0] quotient_mag;

    div_operand_stage #(
        .D_WIDTH (D_WIDTH)
    ) u_operand (
        .clock        (clock),
        .reset        (reset),
        .valid_in     (valid_in),
        .dividend     (dividend),
        .divisor      (divisor),
        .op_release   (valid_out),    // frees the unit on result delivery
        .op_valid     (op_valid),
        .active       (busy),
        .negate       (negate),
        .divisor_zero (divisor_zero),
        .dividend_neg (dividend_neg),
        .dividend_mag (dividend_mag),
        .divisor_mag  (divisor_mag)
    );

    div_nonrestoring_core #(
        .D_WIDTH  (D_WIDTH),
        .Q_BITS   (Q_BITS),
        .ED_WIDTH (ED_WIDTH)
    ) u_core (
        .clock        (clock),
        .reset        (reset),
        .op_valid     (op_valid),
        .dividend_mag (dividend_mag),
        .divisor_mag  (divisor_mag),
        .core_done    (core_done),
        .quotient_mag (quotient_mag)
    );

    div_result_stage #(
        .D_WIDTH  (D_WIDTH),
        .ED_WIDTH (ED_WIDTH)
    ) u_result (
        .clock        (clock),
        .reset        (reset),
        .core_done    (core_done),
        .quotient_mag (quotient_mag),
        .negate       (negate),
        .divisor_zero (divisor_zero),
        .dividend_neg (dividend_neg),
        .quotient     (quotient),
        .status       (status),
        .valid_out    (valid_out)
    );

endmodule

`default_nettype wire

/* design/div_result_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module div_result_stage #(
    parameter int D_WIDTH  = 16,
    parameter int ED_WIDTH = 25
) (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       core_done,
    input  logic        [ED_WIDTH-1:0] quotient_mag,
    input  logic                       negate,
    input  logic                       divisor_zero,
    input  logic                       dividend_neg,
    output logic signed [D_WIDTH-1:0]  quotient,
    output div_ctrl_pkg::div_status_t  status,
    output logic                       valid_out
);

    localparam logic [D_WIDTH-1:0]  MAX_POS   = {1'b0, {(D_WIDTH-1){1'b1}}};
    localparam logic [D_WIDTH-1:0]  MAX_NEG   = {1'b1, {(D_WIDTH-1){1'b0}}};
    localparam logic [ED_WIDTH-1:0] MAG_LIMIT = ED_WIDTH'(1) << (D_WIDTH - 1); // 2^(D_WIDTH-1)

    logic [D_WIDTH-1:0]        quotient_next;
    div_ctrl_pkg::div_status_t status_next;

    always_comb begin
        if (divisor_zero) begin
            quotient_next = dividend_neg ? MAX_NEG : MAX_POS;
            status_next   = div_ctrl_pkg::STATUS_DIV_ZERO;
        end else if (!negate && quotient_mag >= MAG_LIMIT) begin
            quotient_next = MAX_POS; // above 2^(D_WIDTH-1)-1
            status_next   = div_ctrl_pkg::STATUS_OVERFLOW;
        end else if (negate && quotient_mag > MAG_LIMIT) begin
            quotient_next = MAX_NEG; // -2^(D_WIDTH-1) itself is still exact
            status_next   = div_ctrl_pkg::STATUS_OVERFLOW;
        end else if (negate) begin
            quotient_next = D_WIDTH'(0) - quotient_mag[D_WIDTH-1:0];
            status_next   = div_ctrl_pkg::STATUS_OK;
        end else begin
            quotient_next = quotient_mag[D_WIDTH-1:0];
            status_next   = div_ctrl_pkg::STATUS_OK;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            quotient  <= '0;
            status    <= div_ctrl_pkg::STATUS_OK;
            valid_out <= 1'b0;
        end else begin
            valid_out <= core_done; // one pulse per division
            if (core_done) begin
                quotient <= quotient_next; // held until the next result
                status   <= status_next;
            end
        end
    end

endmodule

`default_nettype wire

/* design/div_nonrestoring_core.sv */
`timescale 1ns/1ps
`default_nettype none

module div_nonrestoring_core #(
    parameter int D_WIDTH  = 16,
    parameter int Q_BITS   = 8,
    parameter int ED_WIDTH = D_WIDTH + Q_BITS + 1
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 op_valid,
    input  logic [D_WIDTH-1:0]   dividend_mag,
    input  logic [D_WIDTH-1:0]   divisor_mag,
    output logic                 core_done,
    output logic [ED_WIDTH-1:0]  quotient_mag
);

    localparam int CNT_W = $clog2(ED_WIDTH + 1);

    div_ctrl_pkg::core_state_t state;

    logic [CNT_W-1:0]      iter_count;  // iterations completed
    logic [2*ED_WIDTH:0]   acc;         // {remainder, quotient}
    logic [2*ED_WIDTH:0]   acc_next;
    logic [ED_WIDTH:0]     divisor_ext; // divisor at remainder width
    logic [ED_WIDTH:0]     rem_step;
    logic [ED_WIDTH:0]     rem_final;
    logic [ED_WIDTH-1:0]   preload;
    logic                  last_iter;

    // divisor_mag stays stable while the operand stage is active
    assign divisor_ext = (ED_WIDTH + 1)'(divisor_mag);

    // scaled dividend plus half divisor gives round-to-nearest on truncation
    assign preload = (ED_WIDTH'(dividend_mag) << Q_BITS) + ED_WIDTH'(divisor_mag >> 1);

    assign last_iter = (iter_count == CNT_W'(ED_WIDTH - 1));

    always_comb begin
        // shifted remainder, then add or subtract by the old remainder sign
        if (acc[2*ED_WIDTH]) begin
            rem_step = acc[2*ED_WIDTH-1:ED_WIDTH-1] + divisor_ext;
        end else begin
            rem_step = acc[2*ED_WIDTH-1:ED_WIDTH-1] - divisor_ext;
        end

        // final correction leaves a non-negative remainder
        if (last_iter && rem_step[ED_WIDTH]) begin
            rem_final = rem_step + divisor_ext;
        end else begin
            rem_final = rem_step;
        end

        acc_next = {rem_final, acc[ED_WIDTH-2:0], ~rem_step[ED_WIDTH]}; // new quotient bit
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state      <= div_ctrl_pkg::CORE_IDLE;
            iter_count <= '0;
        end else begin
            case (state)
                div_ctrl_pkg::CORE_IDLE: begin
                    iter_count <= '0;
                    if (op_valid) begin
                        state <= div_ctrl_pkg::CORE_ITERATE;
                    end
                end
                div_ctrl_pkg::CORE_ITERATE: begin
                    iter_count <= iter_count + 1'b1;
                    if (last_iter) begin
                        state <= div_ctrl_pkg::CORE_DONE;
                    end
                end
                div_ctrl_pkg::CORE_DONE: begin
                    state <= div_ctrl_pkg::CORE_IDLE; // single done cycle
                end
                default: begin
                    state <= div_ctrl_pkg::CORE_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == div_ctrl_pkg::CORE_IDLE && op_valid) begin
            acc <= {(ED_WIDTH + 1)'(0), preload};
        end else if (state == div_ctrl_pkg::CORE_ITERATE) begin
            acc <= acc_next;
        end
    end

    assign core_done    = (state == div_ctrl_pkg::CORE_DONE);
    assign quotient_mag = acc[ED_WIDTH-1:0];

endmodule

`default_nettype wire

/* design/div_operand_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module div_operand_stage #(
    parameter int D_WIDTH = 16
) (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       valid_in,
    input  logic signed [D_WIDTH-1:0]  dividend,
    input  logic signed [D_WIDTH-1:0]  divisor,
    input  logic                       op_release,
    output logic                       op_valid,
    output logic                       active,
    output logic                       negate,
    output logic                       divisor_zero,
    output logic                       dividend_neg,
    output logic        [D_WIDTH-1:0]  dividend_mag,
    output logic        [D_WIDTH-1:0]  divisor_mag
);

    logic capture;

    assign capture = valid_in && !active; // new operands only when idle

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            active   <= 1'b0;
            op_valid <= 1'b0;
        end else begin
            op_valid <= capture; // one-cycle start strobe to the core
            if (capture) begin
                active <= 1'b1;
            end else if (op_release) begin
                active <= 1'b0; // result delivered
            end
        end
    end

    // operand payload, held until the next capture
    always_ff @(posedge clock) begin
        if (capture) begin
            // unsigned magnitudes, so the most negative word maps to 2^(D_WIDTH-1)
            dividend_mag <= dividend[D_WIDTH-1] ? (D_WIDTH'(0) - $unsigned(dividend))
                                                : $unsigned(dividend);
            divisor_mag  <= divisor[D_WIDTH-1] ? (D_WIDTH'(0) - $unsigned(divisor))
                                               : $unsigned(divisor);
            negate       <= dividend[D_WIDTH-1] ^ divisor[D_WIDTH-1]; // signs differ
            divisor_zero <= (divisor == '0);
            dividend_neg <= dividend[D_WIDTH-1]; // picks saturation side on div by zero
        end
    end

endmodule

`default_nettype wire

/* design/div_ctrl_pkg.sv */
`default_nettype none

package div_ctrl_pkg;

    // result status reported with each valid_out
    typedef enum logic [1:0] {
        STATUS_OK       = 2'd0, // plain rounded quotient
        STATUS_DIV_ZERO = 2'd1, // divisor was zero, result saturated
        STATUS_OVERFLOW = 2'd2  // quotient out of range, saturated
    } div_status_t;

    // divider core sequencing
    typedef enum logic [1:0] {
        CORE_IDLE    = 2'd0, // waiting for op_valid
        CORE_ITERATE = 2'd1, // one quotient bit per cycle
        CORE_DONE    = 2'd2  // quotient_mag ready, core_done high
    } core_state_t;

endpackage

`default_nettype wire

/* design/fxp_format_pkg.sv */
`default_nettype none

// default fixed-point format for the divide unit
package fxp_format_pkg;

    // total word width, two's complement
    localparam int DEFAULT_D_WIDTH = 16;

    // fractional bits, must stay below the word width
    localparam int DEFAULT_Q_BITS = 8;

endpackage

`default_nettype wire
